// ==== verilog/scope_pkg.sv ====
package scope_pkg;

    ////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////

    // ADC code width
    localparam int SAMPLE_W = 12;

    // Samples per capture, trigger sample included
    localparam int CAPTURE_DEPTH = 256;
    localparam int ADDR_W = 8;

    // Address of the final capture word
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(CAPTURE_DEPTH - 1);

    // Run-time decimation ratio width
    localparam int DECIM_W = 12;

    // Hysteresis band in ADC codes
    localparam int TRIG_HYST = 50;

    ////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////

    // One strobed ADC or decimated sample
    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] data;
    } sample_t;

    // Trigger level, slope 0 rising and 1 falling
    typedef struct packed {
        logic [SAMPLE_W-1:0] level;
        logic                slope;
    } trig_cfg_t;

    // Memory port request, shared by writer and reader
    typedef struct packed {
        logic                valid;
        logic                we;
        logic [ADDR_W-1:0]   addr;
        logic [SAMPLE_W-1:0] data;
    } mem_req_t;

    // Read data back from memory
    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] data;
    } mem_rsp_t;

endpackage

// ==== verilog/sample_decimator.sv ====
module sample_decimator (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     arm,
    input  scope_pkg::sample_t       adc,
    input  logic [scope_pkg::DECIM_W-1:0] decim_ratio,
    output scope_pkg::sample_t       dec_sample
);
    import scope_pkg::*;

    // Ratio of zero behaves like one
    logic [DECIM_W-1:0] ratio_eff;
    // Strobes seen in the current decimation period
    logic [DECIM_W-1:0] count;
    // Count as seen by this cycle's strobe
    logic [DECIM_W-1:0] count_base;
    logic               period_end;

    assign ratio_eff = (decim_ratio == '0) ? DECIM_W'(1) : decim_ratio;

    // Arm restarts the phase, a strobe in the arm cycle counts as the first
    assign count_base = arm ? '0 : count;
    assign period_end = (count_base == ratio_eff - DECIM_W'(1));

    ////////////////////////////////////////////////////////////////////
    // Strobe counter and output register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            count            <= '0;
            dec_sample.valid <= 1'b0;
        end else begin
            dec_sample.valid <= 1'b0;
            if (adc.valid) begin
                if (period_end) begin
                    // Nth strobe goes out, next period starts
                    count            <= '0;
                    dec_sample.valid <= 1'b1;
                    dec_sample.data  <= adc.data;
                end else begin
                    count <= count_base + DECIM_W'(1);
                end
            end else begin
                count <= count_base;
            end
        end
    end

endmodule

// ==== verilog/level_trigger.sv ====
module level_trigger (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 arm,
    input  logic                 busy,
    input  scope_pkg::trig_cfg_t trig_cfg,
    input  scope_pkg::sample_t   dec_sample,
    output logic                 trig_fire
);
    import scope_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_QUIET,
        ARMED
    } trig_state_t;

    trig_state_t state;

    // Config captured at arm, held for the whole attempt
    trig_cfg_t cfg;

    // Band limits around the level, saturated to the code range
    logic [SAMPLE_W:0]   high_sum;
    logic [SAMPLE_W-1:0] band_high;
    logic [SAMPLE_W-1:0] band_low;

    logic quiet;
    logic crossed;

    ////////////////////////////////////////////////////////////////////
    // Hysteresis band
    ////////////////////////////////////////////////////////////////////

    assign high_sum  = {1'b0, cfg.level} + (SAMPLE_W + 1)'(TRIG_HYST);
    assign band_high = high_sum[SAMPLE_W] ? '1 : high_sum[SAMPLE_W-1:0];
    assign band_low  = (cfg.level >= SAMPLE_W'(TRIG_HYST))
                     ? cfg.level - SAMPLE_W'(TRIG_HYST) : '0;

    // Rising needs the signal well below, falling well above
    assign quiet = cfg.slope ? (dec_sample.data >= band_high)
                             : (dec_sample.data <= band_low);

    // Level reached on the chosen slope
    assign crossed = cfg.slope ? (dec_sample.data <= cfg.level)
                               : (dec_sample.data >= cfg.level);

    // Same cycle as the decimated strobe, no extra latency
    assign trig_fire = (state == ARMED) && dec_sample.valid && crossed;

    ////////////////////////////////////////////////////////////////////
    // Arm and cross FSM
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            if (trig_fire) begin
                // One shot per arm
                state <= IDLE;
            end else if (arm && !busy) begin
                state <= WAIT_QUIET;
            end else begin
                case (state)
                    WAIT_QUIET: begin
                        if (dec_sample.valid && quiet) begin
                            state <= ARMED;
                        end
                    end
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // Config register, no reset needed
    always_ff @(posedge clk) begin
        if (arm && !busy && !trig_fire) begin
            cfg <= trig_cfg;
        end
    end

endmodule

// ==== verilog/capture_writer.sv ====
module capture_writer (
    input  logic                clk,
    input  logic                rst,
    input  logic                trig_fire,
    input  scope_pkg::sample_t  dec_sample,
    output scope_pkg::mem_req_t wr_req,
    output logic                busy,
    output logic                capture_done
);
    import scope_pkg::*;

    // Address for the next decimated sample
    logic [ADDR_W-1:0] wr_addr;

    // Final word already on its way to memory
    logic last_issued;

    assign last_issued = wr_req.valid && (wr_req.addr == LAST_ADDR);

    ////////////////////////////////////////////////////////////////////
    // Capture sequencing
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // Strobes default low
        wr_req.valid <= 1'b0;
        capture_done <= 1'b0;
        if (rst) begin
            busy    <= 1'b0;
            wr_addr <= '0;
        end else if (!busy) begin
            if (trig_fire) begin
                // Trigger sample lands at address 0
                wr_req.valid <= 1'b1;
                wr_req.we    <= 1'b1;
                wr_req.addr  <= '0;
                wr_req.data  <= dec_sample.data;
                wr_addr      <= ADDR_W'(1);
                busy         <= 1'b1;
            end
        end else if (last_issued) begin
            // Block complete
            busy         <= 1'b0;
            capture_done <= 1'b1;
        end else if (dec_sample.valid) begin
            wr_req.valid <= 1'b1;
            wr_req.we    <= 1'b1;
            wr_req.addr  <= wr_addr;
            wr_req.data  <= dec_sample.data;
            wr_addr      <= wr_addr + ADDR_W'(1);
        end
    end

endmodule

// ==== verilog/readout_port.sv ====
module readout_port (
    input  logic                clk,
    input  logic                rst,
    input  scope_pkg::mem_req_t rd_req,
    input  logic                rd_grant,
    input  scope_pkg::mem_rsp_t mem_rsp,
    output scope_pkg::mem_req_t rd_mem_req,
    output scope_pkg::mem_rsp_t rd_rsp
);
    import scope_pkg::*;

    // Host request waiting for the memory port
    logic              pending;
    logic [ADDR_W-1:0] rd_addr;

    // Grant history, bit 1 lines up with the memory response
    logic [1:0] grant_d;

    // Held request toward the arbiter
    assign rd_mem_req.valid = pending;
    assign rd_mem_req.we    = 1'b0;
    assign rd_mem_req.addr  = rd_addr;
    assign rd_mem_req.data  = '0;

    // Response two cycles after the grant
    assign rd_rsp.valid = mem_rsp.valid && grant_d[1];
    assign rd_rsp.data  = mem_rsp.data;

    ////////////////////////////////////////////////////////////////////
    // Request hold and grant tracking
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            grant_d <= '0;
        end else begin
            grant_d <= {grant_d[0], rd_grant};
            if (pending) begin
                // Further host requests dropped until taken
                if (rd_grant) begin
                    pending <= 1'b0;
                end
            end else if (rd_req.valid) begin
                pending <= 1'b1;
                rd_addr <= rd_req.addr;
            end
        end
    end

endmodule

// ==== verilog/sample_arbiter.sv ====
module sample_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  scope_pkg::mem_req_t wr_req,
    input  scope_pkg::mem_req_t rd_mem_req,
    output scope_pkg::mem_req_t mem_req,
    output logic                rd_grant
);
    import scope_pkg::*;

    // Request chosen this cycle
    mem_req_t sel;

    ////////////////////////////////////////////////////////////////////
    // Fixed priority select
    ////////////////////////////////////////////////////////////////////

    // Sample stream cannot stall, so the writer always wins
    assign rd_grant = rd_mem_req.valid && !wr_req.valid;

    always_comb begin
        if (wr_req.valid) begin
            sel = wr_req;
        end else begin
            sel    = rd_mem_req;
            // Reads never write, whatever the reader drives
            sel.we = 1'b0;
        end
        sel.valid = wr_req.valid || rd_mem_req.valid;
    end

    ////////////////////////////////////////////////////////////////////
    // Registered memory request
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req.valid <= 1'b0;
        end else begin
            mem_req <= sel;
        end
    end

endmodule

// ==== verilog/sample_ram.sv ====
module sample_ram (
    input  logic                clk,
    input  scope_pkg::mem_req_t mem_req,
    output scope_pkg::mem_rsp_t mem_rsp
);
    import scope_pkg::*;

    // Capture buffer
    logic [SAMPLE_W-1:0] mem [CAPTURE_DEPTH];

    ////////////////////////////////////////////////////////////////////
    // Single port, registered read
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_req.we) begin
            mem[mem_req.addr] <= mem_req.data;
        end
        // Data valid one cycle after a read request
        mem_rsp.valid <= mem_req.valid && !mem_req.we;
        mem_rsp.data  <= mem[mem_req.addr];
    end

endmodule

// ==== verilog/scope_capture_top.sv ====
module scope_capture_top (
    input  logic                          clk,
    input  logic                          rst,
    input  scope_pkg::sample_t            adc,
    input  logic [scope_pkg::DECIM_W-1:0] decim_ratio,
    input  scope_pkg::trig_cfg_t          trig_cfg,
    input  logic                          arm,
    output logic                          capture_done,
    output logic                          busy,
    input  scope_pkg::mem_req_t           rd_req,
    output scope_pkg::mem_rsp_t           rd_rsp
);
    import scope_pkg::*;

    // Decimated stream to trigger and writer
    sample_t  dec_sample;
    logic     trig_fire;

    // Memory port traffic
    mem_req_t wr_req;
    mem_req_t rd_mem_req;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     rd_grant;

    ////////////////////////////////////////////////////////////////////
    // Acquisition path
    ////////////////////////////////////////////////////////////////////

    sample_decimator sample_decimator_inst (
        .clk         (clk),
        .rst         (rst),
        .arm         (arm),
        .adc         (adc),
        .decim_ratio (decim_ratio),
        .dec_sample  (dec_sample)
    );

    level_trigger level_trigger_inst (
        .clk        (clk),
        .rst        (rst),
        .arm        (arm),
        .busy       (busy),
        .trig_cfg   (trig_cfg),
        .dec_sample (dec_sample),
        .trig_fire  (trig_fire)
    );

    capture_writer capture_writer_inst (
        .clk          (clk),
        .rst          (rst),
        .trig_fire    (trig_fire),
        .dec_sample   (dec_sample),
        .wr_req       (wr_req),
        .busy         (busy),
        .capture_done (capture_done)
    );

    ////////////////////////////////////////////////////////////////////
    // Host readout and shared memory
    ////////////////////////////////////////////////////////////////////

    readout_port readout_port_inst (
        .clk        (clk),
        .rst        (rst),
        .rd_req     (rd_req),
        .rd_grant   (rd_grant),
        .mem_rsp    (mem_rsp),
        .rd_mem_req (rd_mem_req),
        .rd_rsp     (rd_rsp)
    );

    sample_arbiter sample_arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .wr_req     (wr_req),
        .rd_mem_req (rd_mem_req),
        .mem_req    (mem_req),
        .rd_grant   (rd_grant)
    );

    sample_ram sample_ram_inst (
        .clk     (clk),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// ==== dv/scope_capture_tb.sv ====
module scope_capture_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import scope_pkg::*;

    localparam int MAX_TESTS = 16;

    // One line of the test file
    typedef struct packed {
        logic [8*24-1:0] name;
        int              decim;
        int              level;
        int              slope;
        int              low;
        int              high;
        int              step;
    } test_t;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    sample_t   adc = '0;
    logic [DECIM_W-1:0] decim_ratio = DECIM_W'(1);
    trig_cfg_t trig_cfg = '0;
    logic      arm = 1'b0;
    mem_req_t  rd_req = '0;
    logic      capture_done;
    logic      busy;
    mem_rsp_t  rd_rsp;

    test_t tests [MAX_TESTS];
    test_t cur;
    int    num_tests = 0;
    int    tests_failed = 0;
    int    checks = 0;
    int    errors = 0;
    int    cycle_count = 0;
    int    cycle_limit = 4000;

    // Model results for the running test
    int exp_cap [CAPTURE_DEPTH];
    int fire_k;

    // Cycle index since the arm strobe, and capture_done history
    int t;
    int done_count;
    int done_t;

    // Host read engine with one request in flight
    logic rd_busy = 1'b0;
    int   rd_exp;
    int   read_q [$];

    scope_capture_top scope_capture_top_inst (
        .clk          (clk),
        .rst          (rst),
        .adc          (adc),
        .decim_ratio  (decim_ratio),
        .trig_cfg     (trig_cfg),
        .arm          (arm),
        .capture_done (capture_done),
        .busy         (busy),
        .rd_req       (rd_req),
        .rd_rsp       (rd_rsp)
    );

    always #5 clk = ~clk;

    // Run limit set from the test lengths
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run passed %0d cycles without finishing", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Triangle wave from low up to high and back
    function automatic int wave_at(input test_t tc, input int k);
        int half;
        int p;
        half = (tc.high - tc.low) / tc.step;
        p = k % (2 * half);
        if (p <= half) begin
            return tc.low + p * tc.step;
        end
        return tc.high - (p - half) * tc.step;
    endfunction

    // Raw index of the firing sample or -1 when nothing fires in the window
    function automatic int find_fire(input test_t tc, input int n, input int window);
        int   lo;
        int   hi;
        int   d;
        logic armed;
        lo = (tc.level >= TRIG_HYST) ? tc.level - TRIG_HYST : 0;
        hi = tc.level + TRIG_HYST;
        if (hi > (1 << SAMPLE_W) - 1) begin
            hi = (1 << SAMPLE_W) - 1;
        end
        armed = 1'b0;
        // Every Nth strobe counted from the one in the arm cycle
        for (int k = n - 1; k < window; k += n) begin
            d = wave_at(tc, k);
            if (!armed) begin
                armed = (tc.slope != 0) ? (d >= hi) : (d <= lo);
            end else if ((tc.slope != 0) ? (d <= tc.level) : (d >= tc.level)) begin
                return k;
            end
        end
        return -1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and cycle driver
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %0s %0s expected %0d actual %0d",
                     cur.name, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR in %0s: %0s", cur.name, msg);
    endtask

    // Sample outputs, serve the host read, then drive the next ADC strobe
    task automatic advance_cycle(input logic do_arm);
        int addr;
        @(posedge clk);
        #1;
        if (capture_done) begin
            done_count++;
            done_t = t;
            check_value("busy at capture_done", 0, int'(busy));
        end
        if (fire_k >= 0 && t == fire_k + 2) begin
            check_value("busy after trigger", 1, int'(busy));
        end
        if (rd_rsp.valid) begin
            if (!rd_busy) begin
                report_error("read response arrived with no read pending");
            end else begin
                check_value("read data", rd_exp, int'(rd_rsp.data));
            end
            rd_busy = 1'b0;
        end
        rd_req = '0;
        if (!rd_busy && read_q.size() > 0) begin
            addr         = read_q.pop_front();
            rd_exp       = exp_cap[addr];
            rd_req.valid = 1'b1;
            rd_req.addr  = ADDR_W'(addr);
            rd_busy      = 1'b1;
        end
        arm       = do_arm;
        adc.valid = 1'b1;
        adc.data  = SAMPLE_W'(wave_at(cur, t));
        t++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // One test configures, arms, captures and reads back
    //////////////////////////////////////////////////////////////////////

    task automatic run_test(input test_t tc);
        int n;
        int window;
        int exp_done;
        int max_a;
        int j;
        int tmp;
        int errors_before;
        cur           = tc;
        errors_before = errors;
        n        = (tc.decim == 0) ? 1 : tc.decim;
        window   = (2 * (tc.high - tc.low) / tc.step + CAPTURE_DEPTH) * n * 2;
        fire_k   = find_fire(tc, n, window);
        exp_done = fire_k + (CAPTURE_DEPTH - 1) * n + 3;
        if (fire_k >= 0) begin
            for (int i = 0; i < CAPTURE_DEPTH; i++) begin
                exp_cap[i] = wave_at(tc, fire_k + i * n);
            end
        end
        // Stream paused while the new config settles
        @(posedge clk);
        #1;
        adc            = '0;
        arm            = 1'b0;
        decim_ratio    = DECIM_W'(tc.decim);
        trig_cfg.level = SAMPLE_W'(tc.level);
        trig_cfg.slope = tc.slope[0];
        repeat (4) @(posedge clk);
        t          = 0;
        done_count = 0;
        done_t     = -1;
        advance_cycle(1'b1);
        if (fire_k < 0) begin
            while (t < window) begin
                advance_cycle(1'b0);
            end
            if (done_count != 0) begin
                report_error("the trigger fired without a crossing");
            end
        end else begin
            while (done_count == 0 && t <= exp_done + 8) begin
                // Reads of words already in memory race the writer
                if (!rd_busy && read_q.size() == 0 && t >= fire_k + 8) begin
                    max_a = (t - fire_k - 8) / n;
                    if (max_a > CAPTURE_DEPTH - 1) begin
                        max_a = CAPTURE_DEPTH - 1;
                    end
                    read_q.push_back(int'($urandom_range(max_a, 0)));
                end
                advance_cycle(1'b0);
            end
            if (done_count == 0) begin
                report_error("capture_done never arrived");
            end else begin
                check_value("capture_done cycle", exp_done, done_t);
            end
            // Whole block in shuffled order
            for (int i = 0; i < CAPTURE_DEPTH; i++) begin
                read_q.push_back(i);
            end
            for (int i = CAPTURE_DEPTH - 1; i > 0; i--) begin
                j         = int'($urandom_range(i, 0));
                tmp       = read_q[i];
                read_q[i] = read_q[j];
                read_q[j] = tmp;
            end
            while (rd_busy || read_q.size() > 0) begin
                advance_cycle(1'b0);
            end
        end
        if (errors == errors_before) begin
            $display("test %0s: ok", tc.name);
        end else begin
            tests_failed++;
            $display("test %0s: %0d errors", tc.name, errors - errors_before);
        end
    endtask

    initial begin
        int    fd;
        int    cnt;
        int    n;
        string line_buf;
        test_t tc;
        void'($urandom(32'h22470991));
        fd = $fopen("dv/scope_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: test file dv/scope_tests.txt could not be opened");
        end else begin
            // Comment and blank lines do not scan as seven fields
            while ($fgets(line_buf, fd) != 0) begin
                cnt = $sscanf(line_buf, "%s %d %d %d %d %d %d", tc.name, tc.decim,
                              tc.level, tc.slope, tc.low, tc.high, tc.step);
                if (cnt == 7 && num_tests < MAX_TESTS) begin
                    tests[num_tests] = tc;
                    num_tests++;
                    n = (tc.decim == 0) ? 1 : tc.decim;
                    cycle_limit += (2 * (tc.high - tc.low) / tc.step + CAPTURE_DEPTH) * n * 3;
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            run_test(tests[i]);
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 num_tests, tests_failed, checks, errors);
        if (errors == 0 && num_tests > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/scope_tests.txt ====
# name decim level slope low high step (decimal, slope 0 rising and 1 falling)
# triangle wave starts at low and climbs by step to high, then falls back
rise_d1      1  2000  0   500  3500  25
fall_d1      1  1500  1   200  3800  40
rise_d3      3  2500  0   100  4000  30
fall_d17    17  1000  1   300  3300  50
hyst_fall    1  2000  1  1980  3000  20
arb_d4       4  1800  0   400  3600  20
no_cross     2  3000  0   500  2000  25

// ==== files.f ====
verilog/scope_pkg.sv
verilog/sample_decimator.sv
verilog/level_trigger.sv
verilog/capture_writer.sv
verilog/readout_port.sv
verilog/sample_arbiter.sv
verilog/sample_ram.sv
verilog/scope_capture_top.sv
dv/scope_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the scope capture testbench with Verilator
verilator --binary --timing --timescale 1ns/1ps --top-module scope_capture_tb \
    -f files.f -o scope_sim || exit 1
./obj_dir/scope_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0
